// File: src.f
+incdir+.
graph_pkg.sv
step_csr.sv
walk_ctrl.sv
line_read_engine.sv
level_table.sv
edge_filter.sv
result_writer.sv
level_step_top.sv
level_step_chk.sv
tb_level_step.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_level_step -o tb_level_step
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_level_step)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

// File: tb_level_step.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module tb_level_step;
    import graph_pkg::*;

    localparam logic [31:0] IDLE_READ = 32'h0;    // idle code zero, busy bit clear.

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      csr_wr;
    logic [`CSR_ADDR_BITS-1:0] csr_addr;
    logic [`CSR_DATA_BITS-1:0] csr_wdata;
    logic [`CSR_DATA_BITS-1:0] csr_rdata;
    logic                      rd_req;
    cl_addr_t                  rd_addr;
    logic                      rd_rsp = 1'b0;
    line_t                     rd_data = '0;
    logic                      wr_req;
    cl_addr_t                  wr_addr;
    line_t                     wr_data;
    logic                      walk_done;

    int       seed = 58;
    int       cycle = 0;
    int       lat;
    int       walk_count = 0;
    cl_addr_t alloc_ptr = 32'h100;
    cl_addr_t rsp_addr;
    cl_addr_t want_addr;
    line_t    want_data;
    cl_addr_t first;
    line_t    mem [cl_addr_t];
    cl_addr_t rq_addr [$];
    int       rq_due [$];
    cl_addr_t exp_addr [$];
    line_t    exp_data [$];

    level_step_top i_level_step_top (
        .clk, .reset, .csr_wr, .csr_addr, .csr_wdata, .csr_rdata, .rd_req, .rd_addr,
        .rd_rsp, .rd_data, .wr_req, .wr_addr, .wr_data, .walk_done
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%0t ns: %s", $time, reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // ====================
    // memory model
    // ====================
    always @(posedge clk) begin
        cycle = cycle + 1;
        rd_rsp <= 1'b0;
        if (walk_done) begin
            walk_count = walk_count + 1;
        end
        if (rd_req) begin
            lat = 1 + (($random(seed) & 32'h7fffffff) % 6);
            rq_addr.push_back(rd_addr);
            rq_due.push_back(cycle + lat);
        end
        if (rq_due.size() > 0 && rq_due[0] <= cycle) begin
            rsp_addr = rq_addr.pop_front();
            void'(rq_due.pop_front());
            rd_rsp  <= 1'b1;
            rd_data <= mem.exists(rsp_addr) ? mem[rsp_addr] : '0;
        end
        if (wr_req) begin
            if (exp_addr.size() == 0) begin
                abort_run("memory write seen with no write left to expect");
            end else begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                check_value(line_t'(wr_addr), line_t'(want_addr), "write address");
                check_value(wr_data, want_data, "write data");
            end
        end
    end

    function automatic cl_addr_t alloc_lines(input int n);
        alloc_lines = alloc_ptr;
        alloc_ptr = alloc_ptr + cl_addr_t'(n) + 32'd4;   // small gap between blocks.
    endfunction

    // ====================
    // descriptors and reference model
    // ====================
    task automatic make_descriptor(input cl_addr_t at, input cl_addr_t next, input int n_edge);
        logic [15:0] levels [256];
        int          n_vert;
        int          lvl;
        int          src_i;
        int          count;
        int          k;
        logic [15:0] dst;
        cl_addr_t    v_addr;
        cl_addr_t    e_addr;
        cl_addr_t    u_addr;
        cl_addr_t    s_addr;
        line_t       line;
        line_t       upd;
        n_vert = 1 + ($random(seed) & 15);
        lvl    = $random(seed) & 3;
        v_addr = alloc_lines(n_vert);
        e_addr = alloc_lines(n_edge);
        u_addr = alloc_lines(n_edge);
        s_addr = alloc_lines(1);
        for (int v = 0; v < n_vert; v++) begin
            line = '0;
            for (int j = 0; j < 16; j++) begin
                levels[v*16 + j] = 16'($random(seed) & 3);
                line[j*16 +: 16] = levels[v*16 + j];
            end
            mem[v_addr + cl_addr_t'(v)] = line;
        end
        count = 0;
        k = 0;
        for (int e = 0; e < n_edge; e++) begin
            line = '0;
            upd  = '0;
            for (int i = 0; i < 8; i++) begin
                src_i = ($random(seed) & 32'h7fffffff) % (n_vert * 16);
                dst   = 16'($random(seed));
                line[i*32 +: 32] = {dst, 16'(src_i)};
                if (levels[src_i] == 16'(lvl)) begin
                    upd[i*32 +: 32] = {1'b1, 15'b0, dst};
                    count = count + 1;
                end
            end
            mem[e_addr + cl_addr_t'(e)] = line;
            if (upd != '0) begin                          // empty lines are never written.
                exp_addr.push_back(u_addr + cl_addr_t'(k));
                exp_data.push_back(upd);
                k = k + 1;
            end
        end
        exp_addr.push_back(s_addr);
        exp_data.push_back(line_t'({1'b1, count}));
        line = '0;
        line[31:0]    = next;
        line[63:32]   = v_addr;
        line[95:64]   = 32'(n_vert);
        line[127:96]  = e_addr;
        line[159:128] = 32'(n_edge);
        line[191:160] = u_addr;
        line[223:192] = s_addr;
        line[255:224] = 32'(lvl);
        mem[at] = line;
    endtask

    task automatic build_chain(input int n_desc, input bit no_edges, output cl_addr_t head);
        cl_addr_t at;
        cl_addr_t next;
        int       n_edge;
        at   = alloc_lines(1);
        head = at;
        for (int d = 0; d < n_desc; d++) begin
            next   = (d == n_desc - 1) ? '0 : alloc_lines(1);
            n_edge = no_edges ? 0 : 1 + ($random(seed) & 7);
            make_descriptor(at, next, n_edge);
            at = next;
        end
    endtask

    task automatic read_csr(input int addr, output logic [31:0] data);
        @(posedge clk);
        csr_addr <= `CSR_ADDR_BITS'(addr);
        @(posedge clk);
        data = csr_rdata;
    endtask

    task automatic run_walk(input cl_addr_t head, input int n_desc);
        logic [31:0] done_before;
        logic [31:0] done_after;
        logic [31:0] control;
        int          walks_before;
        int          cycles;
        read_csr(`CSR_DESC_DONE, done_before);
        walks_before = walk_count;
        @(posedge clk);
        csr_wr    <= 1'b1;
        csr_addr  <= `CSR_ADDR_BITS'(`CSR_CONTROL);
        csr_wdata <= head;
        @(posedge clk);
        csr_wr <= 1'b0;
        read_csr(`CSR_CONTROL, control);
        check_value(line_t'(control[8]), line_t'(1'b1), "busy bit during walk");
        cycles = 0;
        while (walk_done !== 1'b1) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > 20000) begin
                abort_run("timeout while waiting for walk_done");
            end
        end
        repeat (4) @(posedge clk);
        check_value(line_t'(walk_count - walks_before), line_t'(1), "walk_done pulses");
        check_value(line_t'(exp_addr.size()), '0, "expected writes left over");
        read_csr(`CSR_DESC_DONE, done_after);
        check_value(line_t'(done_after), line_t'(done_before + 32'(n_desc)), "descriptor count");
        read_csr(`CSR_CONTROL, control);
        check_value(line_t'(control), line_t'(IDLE_READ), "control register after walk");
    endtask

    initial begin
        logic [31:0] value;
        reset     = 1'b1;
        csr_wr    = 1'b0;
        csr_addr  = '0;
        csr_wdata = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // bus stays quiet until started.
        repeat (6) begin
            @(posedge clk);
            check_value(line_t'({rd_req, wr_req, walk_done}), '0, "strobe before start");
        end
        read_csr(`CSR_CONTROL, value);
        check_value(line_t'(value), line_t'(IDLE_READ), "control register after reset");

        build_chain(1, 1'b0, first);
        run_walk(first, 1);
        build_chain(3, 1'b0, first);
        run_walk(first, 3);
        build_chain(1, 1'b1, first);                      // no edge lines.
        run_walk(first, 1);
        build_chain(2, 1'b0, first);
        run_walk(first, 2);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: level_step_chk.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module level_step_chk (
    input logic clk,
    input logic reset,
    input logic rd_req,
    input logic rd_rsp,
    input logic wr_req,
    input logic walk_done
);

    logic [7:0] in_flight;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + 8'(rd_req) - 8'(rd_rsp);   // requests not yet answered.
        end
    end

    // ====================
    // protocol properties
    // ====================
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!rd_req && !wr_req && !walk_done))
        else $error("memory strobe or walk_done high around reset");

    outstanding_cap: assert property (@(posedge clk) disable iff (reset)
        in_flight <= 8'(`MAX_OUTSTANDING))
        else $error("too many read requests in flight");

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        walk_done |=> !walk_done)
        else $error("walk_done held longer than one cycle");

endmodule

bind level_step_top level_step_chk i_level_step_chk (
    .clk, .reset, .rd_req, .rd_rsp, .wr_req, .walk_done
);

// File: level_step_top.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module level_step_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       csr_wr,
    input  logic [`CSR_ADDR_BITS-1:0]  csr_addr,
    input  logic [`CSR_DATA_BITS-1:0]  csr_wdata,
    output logic [`CSR_DATA_BITS-1:0]  csr_rdata,
    output logic                       rd_req,
    output graph_pkg::cl_addr_t        rd_addr,
    input  logic                       rd_rsp,
    input  graph_pkg::line_t           rd_data,
    output logic                       wr_req,
    output graph_pkg::cl_addr_t        wr_addr,
    output graph_pkg::line_t           wr_data,
    output logic                       walk_done
);

    logic                  start;
    graph_pkg::cl_addr_t   first_desc;
    graph_pkg::walk_state_t state;
    logic                  desc_done;

    logic                  read_start;
    graph_pkg::cl_addr_t   read_base;
    logic [31:0]           read_ncl;
    logic                  read_done;

    logic                  vertex_load;
    logic                  edge_pass;
    logic                  table_clear;
    graph_pkg::level_t     level;
    graph_pkg::cl_addr_t   update_addr;
    graph_pkg::cl_addr_t   status_addr;
    logic                  status_go;
    logic                  status_done;

    logic [`EDGE_LANES-1:0][$clog2(`TABLE_DEPTH)-1:0] lane_src;
    graph_pkg::level_t [`EDGE_LANES-1:0]               lane_level;
    logic                  upd_valid;
    graph_pkg::line_t      upd_line;

    // ====================
    // control
    // ====================
    step_csr i_step_csr (
        .clk, .reset, .csr_wr, .csr_addr, .csr_wdata, .csr_rdata,
        .state, .desc_done, .start, .first_desc
    );

    walk_ctrl i_walk_ctrl (
        .clk, .reset, .start, .first_desc, .rd_rsp, .rd_data, .read_done,
        .status_done, .read_start, .read_base, .read_ncl, .vertex_load,
        .edge_pass, .table_clear, .level, .update_addr, .status_addr,
        .status_go, .desc_done, .state, .walk_done
    );

    // ====================
    // datapath
    // ====================
    line_read_engine i_line_read_engine (
        .clk, .reset, .read_start, .read_base, .read_ncl, .rd_rsp,
        .rd_req, .rd_addr, .read_done
    );

    level_table i_level_table (
        .clk, .table_clear, .vertex_load, .rd_rsp, .rd_data, .lane_src, .lane_level
    );

    edge_filter i_edge_filter (
        .clk, .reset, .edge_pass, .rd_rsp, .rd_data, .level, .lane_level,
        .lane_src, .upd_valid, .upd_line
    );

    result_writer i_result_writer (
        .clk, .reset, .upd_valid, .upd_line, .update_addr, .status_addr,
        .status_go, .desc_done, .wr_req, .wr_addr, .wr_data, .status_done
    );

endmodule

// File: result_writer.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module result_writer (
    input  logic                clk,
    input  logic                reset,
    input  logic                upd_valid,
    input  graph_pkg::line_t    upd_line,
    input  graph_pkg::cl_addr_t update_addr,
    input  graph_pkg::cl_addr_t status_addr,
    input  logic                status_go,
    input  logic                desc_done,
    output logic                wr_req,
    output graph_pkg::cl_addr_t wr_addr,
    output graph_pkg::line_t    wr_data,
    output logic                status_done
);
    import graph_pkg::*;

    localparam int LANE_BITS = `LINE_BITS / `EDGE_LANES;

    cl_addr_t    line_k;
    logic [31:0] entry_count;
    logic [31:0] line_marks;

    // marked lanes carry bit 31.
    always_comb begin
        line_marks = '0;
        for (int i = 0; i < `EDGE_LANES; i++) begin
            line_marks = line_marks + 32'(upd_line[i*LANE_BITS + 31]);
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid) begin
            wr_addr <= update_addr + line_k;
            wr_data <= upd_line;
        end else if (status_go) begin
            wr_addr <= status_addr;
            wr_data <= line_t'({1'b1, entry_count});   // done flag over the count.
        end
        if (reset) begin
            wr_req      <= 1'b0;
            status_done <= 1'b0;
            line_k      <= '0;
            entry_count <= '0;
        end else begin
            wr_req      <= upd_valid || status_go;
            status_done <= status_go;
            if (desc_done) begin
                line_k      <= '0;
                entry_count <= '0;
            end else if (upd_valid) begin
                line_k      <= line_k + 1'b1;
                entry_count <= entry_count + line_marks;
            end
        end
    end

endmodule

// File: edge_filter.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module edge_filter (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       edge_pass,
    input  logic                                       rd_rsp,
    input  graph_pkg::line_t                           rd_data,
    input  graph_pkg::level_t                          level,
    input  graph_pkg::level_t [`EDGE_LANES-1:0]        lane_level,
    output logic [`EDGE_LANES-1:0][$clog2(`TABLE_DEPTH)-1:0] lane_src,
    output logic                                       upd_valid,
    output graph_pkg::line_t                           upd_line
);
    import graph_pkg::*;

    localparam int LANE_BITS = `LINE_BITS / `EDGE_LANES;

    logic [`EDGE_LANES-1:0] match;
    line_t                  next_line;
    vertex_id_t             dst;

    // each lane is {dst, src} in 32 bits.
    always_comb begin
        next_line = '0;
        for (int i = 0; i < `EDGE_LANES; i++) begin
            lane_src[i] = rd_data[i*LANE_BITS +: $clog2(`TABLE_DEPTH)];
            dst         = rd_data[i*LANE_BITS + 16 +: 16];
            match[i]    = (lane_level[i] == level);
            if (match[i]) begin
                next_line[i*LANE_BITS +: LANE_BITS] = {1'b1, 15'b0, dst};
            end
        end
    end

    always_ff @(posedge clk) begin
        upd_line <= next_line;
        if (reset) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= edge_pass && rd_rsp && (|match);  // nothing sent for empty lines.
        end
    end

endmodule

// File: level_table.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module level_table (
    input  logic                                       clk,
    input  logic                                       table_clear,
    input  logic                                       vertex_load,
    input  logic                                       rd_rsp,
    input  graph_pkg::line_t                           rd_data,
    input  logic [`EDGE_LANES-1:0][$clog2(`TABLE_DEPTH)-1:0] lane_src,
    output graph_pkg::level_t [`EDGE_LANES-1:0]        lane_level
);
    import graph_pkg::*;

    localparam int SLOT_BITS = $clog2(`LEVELS_PER_LINE);
    localparam int LINE_BITS = $clog2(`TABLE_DEPTH) - SLOT_BITS;

    level_t               mem [`TABLE_DEPTH];
    logic [LINE_BITS-1:0] line_idx;

    always_ff @(posedge clk) begin
        if (table_clear) begin
            line_idx <= '0;
        end else if (vertex_load && rd_rsp) begin
            for (int j = 0; j < `LEVELS_PER_LINE; j++) begin
                mem[{line_idx, SLOT_BITS'(j)}] <= rd_data[j*`LEVEL_BITS +: `LEVEL_BITS];
            end
            line_idx <= line_idx + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `EDGE_LANES; i++) begin
            lane_level[i] = mem[lane_src[i]];
        end
    end

endmodule

// File: line_read_engine.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module line_read_engine (
    input  logic                clk,
    input  logic                reset,
    input  logic                read_start,
    input  graph_pkg::cl_addr_t read_base,
    input  logic [31:0]         read_ncl,
    input  logic                rd_rsp,
    output logic                rd_req,
    output graph_pkg::cl_addr_t rd_addr,
    output logic                read_done
);
    import graph_pkg::*;

    localparam int OUT_BITS = $clog2(`MAX_OUTSTANDING + 1);

    cl_addr_t            next_addr;
    logic [31:0]         req_left;
    logic [31:0]         rsp_left;
    logic [OUT_BITS-1:0] in_flight;
    logic                active;

    assign rd_req  = active && (req_left != '0) && (in_flight < OUT_BITS'(`MAX_OUTSTANDING));
    assign rd_addr = next_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            read_done <= 1'b0;
            req_left  <= '0;
            rsp_left  <= '0;
            in_flight <= '0;
        end else begin
            read_done <= 1'b0;
            in_flight <= in_flight + OUT_BITS'(rd_req) - OUT_BITS'(rd_rsp);
            if (read_start) begin
                next_addr <= read_base;
                req_left  <= read_ncl;
                rsp_left  <= read_ncl;
                active    <= (read_ncl != '0);
                read_done <= (read_ncl == '0);            // empty run.
            end else if (active) begin
                if (rd_req) begin
                    next_addr <= next_addr + 1'b1;
                    req_left  <= req_left - 1'b1;
                end
                if (rd_rsp) begin
                    rsp_left <= rsp_left - 1'b1;
                    if (rsp_left == 32'd1) begin
                        active    <= 1'b0;
                        read_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: walk_ctrl.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module walk_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  graph_pkg::cl_addr_t    first_desc,
    input  logic                   rd_rsp,
    input  graph_pkg::line_t       rd_data,
    input  logic                   read_done,
    input  logic                   status_done,
    output logic                   read_start,
    output graph_pkg::cl_addr_t    read_base,
    output logic [31:0]            read_ncl,
    output logic                   vertex_load,
    output logic                   edge_pass,
    output logic                   table_clear,
    output graph_pkg::level_t      level,
    output graph_pkg::cl_addr_t    update_addr,
    output graph_pkg::cl_addr_t    status_addr,
    output logic                   status_go,
    output logic                   desc_done,
    output graph_pkg::walk_state_t state,
    output logic                   walk_done
);
    import graph_pkg::*;

    desc_t desc;
    logic  drain_cnt;

    // descriptor line arrives once per read_desc.
    always_ff @(posedge clk) begin
        if (state == st_read_desc && rd_rsp) begin
            desc <= desc_t'(rd_data);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            read_start <= 1'b0;
            status_go  <= 1'b0;
            desc_done  <= 1'b0;
            drain_cnt  <= 1'b0;
        end else begin
            read_start <= 1'b0;
            status_go  <= 1'b0;
            desc_done  <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        read_start <= 1'b1;
                        read_base  <= first_desc;
                        read_ncl   <= 32'd1;
                        state      <= st_read_desc;
                    end
                end
                st_read_desc: begin
                    if (read_done) begin
                        read_start <= 1'b1;
                        read_base  <= desc.vertex_addr;
                        read_ncl   <= desc.vertex_ncl;
                        state      <= st_load_vertex;
                    end
                end
                st_load_vertex: begin
                    if (read_done) begin
                        read_start <= 1'b1;
                        read_base  <= desc.edge_addr;
                        read_ncl   <= desc.edge_ncl;
                        state      <= st_filter_edge;
                    end
                end
                st_filter_edge: begin
                    if (read_done) begin
                        drain_cnt <= 1'b0;
                        state     <= st_drain;
                    end
                end
                st_drain: begin
                    // let the last update line reach memory.
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        status_go <= 1'b1;
                        state     <= st_write_status;
                    end
                end
                st_write_status: begin
                    if (status_done) begin
                        desc_done <= 1'b1;
                        if (desc.next_desc_addr == '0) begin
                            state <= st_finish;
                        end else begin
                            read_start <= 1'b1;
                            read_base  <= desc.next_desc_addr;
                            read_ncl   <= 32'd1;
                            state      <= st_read_desc;
                        end
                    end
                end
                default: state <= st_idle;                // st_finish.
            endcase
        end
    end

    assign vertex_load = (state == st_load_vertex);
    assign edge_pass   = (state == st_filter_edge);
    assign table_clear = (state == st_read_desc);         // line counter back to zero.
    assign walk_done   = (state == st_finish);
    assign level       = level_t'(desc.level);
    assign update_addr = desc.update_addr;
    assign status_addr = desc.status_addr;

endmodule

// File: step_csr.sv
`timescale 1ns/1ps
`include "graph_cfg.svh"

module step_csr (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       csr_wr,
    input  logic [`CSR_ADDR_BITS-1:0]  csr_addr,
    input  logic [`CSR_DATA_BITS-1:0]  csr_wdata,
    input  graph_pkg::walk_state_t     state,
    input  logic                       desc_done,
    output logic                       start,
    output graph_pkg::cl_addr_t        first_desc,
    output logic [`CSR_DATA_BITS-1:0]  csr_rdata
);
    import graph_pkg::*;

    logic [`CSR_DATA_BITS-1:0] desc_count;
    logic                      ctl_write;
    logic                      busy;

    assign ctl_write = csr_wr && (csr_addr == `CSR_ADDR_BITS'(`CSR_CONTROL));
    assign busy      = (state != st_idle);

    always_ff @(posedge clk) begin
        if (ctl_write) begin
            first_desc <= cl_addr_t'(csr_wdata);
        end
        if (reset) begin
            start      <= 1'b0;
            desc_count <= '0;
        end else begin
            start <= ctl_write;                           // one-cycle kick.
            if (desc_done) begin
                desc_count <= desc_count + 1'b1;
            end
        end
    end

    always_comb begin
        case (csr_addr)
            `CSR_ADDR_BITS'(`CSR_CONTROL):   csr_rdata = `CSR_DATA_BITS'({busy, 8'(state)});
            `CSR_ADDR_BITS'(`CSR_DESC_DONE): csr_rdata = desc_count;
            default:                         csr_rdata = '0;
        endcase
    end

endmodule

// File: graph_pkg.sv
`include "graph_cfg.svh"

package graph_pkg;

    typedef logic [`LINE_BITS-1:0]  line_t;
    typedef logic [`ADDR_BITS-1:0]  cl_addr_t;
    typedef logic [`LEVEL_BITS-1:0] level_t;
    typedef logic [15:0]            vertex_id_t;

    // packed structs fill from the top, so the last field lands in bits 31:0.
    typedef struct packed {
        logic [31:0] level;           // level in low 16 bits.
        cl_addr_t    status_addr;
        cl_addr_t    update_addr;
        logic [31:0] edge_ncl;
        cl_addr_t    edge_addr;
        logic [31:0] vertex_ncl;      // at most 16 lines.
        cl_addr_t    vertex_addr;
        cl_addr_t    next_desc_addr;  // zero ends the chain.
    } desc_t;

    typedef enum logic [2:0] {
        st_idle,
        st_read_desc,
        st_load_vertex,
        st_filter_edge,
        st_drain,
        st_write_status,
        st_finish
    } walk_state_t;

endpackage

// File: graph_cfg.svh
`ifndef GRAPH_CFG_SVH
`define GRAPH_CFG_SVH

// ====================
// memory geometry
// ====================
`define LINE_BITS       256
`define ADDR_BITS       32

// vertex table and edge lanes
`define LEVEL_BITS      16
`define LEVELS_PER_LINE 16
`define TABLE_DEPTH     256
`define EDGE_LANES      8
`define MAX_OUTSTANDING 8

// ====================
// register block
// ====================
`define CSR_ADDR_BITS   4
`define CSR_DATA_BITS   32
`define CSR_CONTROL     0
`define CSR_DESC_DONE   1

`endif
